// ==== bus_glue_pkg.sv ====
// shared bus types for the Z180 glue; I/O ports decode a[7:0] only, upper address bits ignored
package bus_glue_pkg;

    // *******************************************************************
    // CPU bus, sampled straight from the pins
    // *******************************************************************
    typedef struct packed {
        logic [19:0] a;         // 1 MB physical address
        logic        mreq_n;    // memory request
        logic        iorq_n;    // io request
        logic        rd_n;      // read strobe
        logic        wr_n;      // write strobe
        logic        m1_n;      // opcode fetch, low with iorq_n on int ack
    } cpu_bus_t;

    // static RAM controls, all active low
    typedef struct packed {
        logic ce_n;
        logic oe_n;
        logic we_n;
    } mem_strobe_t;

    // who owns the read data this cycle
    typedef enum logic [1:0] {
        RD_SRC_NONE = 2'd0,
        RD_SRC_ROM  = 2'd1,
        RD_SRC_IO   = 2'd2
    } rd_src_t;

    // *******************************************************************
    // io port map, compared with a[7:0]
    // *******************************************************************
    localparam logic [7:0] LED_PORT     = 8'h40;
    localparam logic [7:0] SCRATCH_PORT = 8'h41;
    localparam logic [7:0] STATUS_PORT  = 8'h42;
    localparam logic [7:0] IRQ_PORT     = 8'h43;

    // bus cycle qualifiers
    function automatic logic is_mem_rd(cpu_bus_t b);
        return ~b.mreq_n & ~b.rd_n;
    endfunction

    function automatic logic is_io(cpu_bus_t b);
        return ~b.iorq_n & b.m1_n;  // int ack (m1_n low) is not an io cycle
    endfunction

endpackage

// ==== boot_rom.sv ====
// boot ROM loaded from boot_rom.hex at elaboration; file must hold 2**ROM_ADDR_BITS bytes
`timescale 1ns/1ps

module boot_rom #(
    parameter int ROM_ADDR_BITS = 9        // depth is 2**ROM_ADDR_BITS bytes
) (
    input  logic                     hwclk,
    input  logic [ROM_ADDR_BITS-1:0] addr,
    output logic [7:0]               q
);

    localparam int ROM_BYTES = 2 ** ROM_ADDR_BITS;

    logic [7:0] mem [0:ROM_BYTES-1];        // maps onto block RAM in read-only use

    // contents come from the firmware build
    initial begin
        $readmemh("boot_rom.hex", mem);
    end

    // synchronous read, q follows addr one edge later
    always_ff @(posedge hwclk) begin
        q <= mem[addr];
    end

endmodule

// ==== mem_decode.sv ====
// memory decode for 20-bit bus; ROM_ADDR_BITS must stay below 20, ROM at bottom, SRAM above
`timescale 1ns/1ps

module mem_decode
    import bus_glue_pkg::*;
#(
    parameter int ROM_ADDR_BITS = 9
) (
    input  logic        hwclk,
    input  cpu_bus_t    bus,
    output mem_strobe_t strobes,
    output logic        rom_rd,     // ROM read seen at previous edge, lines up with rom_q
    output logic [7:0]  rom_q
);

    localparam int unsigned ROM_BYTES = 1 << ROM_ADDR_BITS;

    logic in_rom;       // address falls in boot ROM window
    logic rom_rd_q;

    // *******************************************************************
    // region split
    // *******************************************************************
    assign in_rom = (32'(bus.a) < ROM_BYTES);

    // SRAM strobes are pure decode, no clock in the path
    always_comb begin
        strobes.ce_n = ~(~bus.mreq_n & ~in_rom);   // SRAM only above the ROM
        strobes.oe_n = bus.mreq_n | bus.rd_n;
        strobes.we_n = bus.mreq_n | bus.wr_n;      // ROM writes fall on the floor
    end

    // *******************************************************************
    // boot ROM read path
    // *******************************************************************
    boot_rom #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS)
    ) u_boot_rom (
        .hwclk (hwclk),
        .addr  (bus.a[ROM_ADDR_BITS-1:0]),
        .q     (rom_q)
    );

    // qualifier delayed to match the rom output register
    always_ff @(posedge hwclk) begin
        rom_rd_q <= is_mem_rd(bus) & in_rom;
    end

    assign rom_rd = rom_rd_q;

endmodule

// ==== io_ports.sv ====
// io port block; one write per strobe assertion, ports decoded on a[7:0] only, int ack ignored
`timescale 1ns/1ps

module io_ports
    import bus_glue_pkg::*;
(
    input  logic       hwclk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  logic [7:0] d_in,
    input  logic       halt_n,
    input  logic       busack_n,
    output logic       io_rd,      // io read seen at previous edge
    output logic [7:0] io_q,       // port data for that read
    output logic [7:0] led,        // active low
    output logic [2:0] int_n,
    output logic       nmi_n
);

    logic       wr_cond;        // io write strobe active now
    logic       wr_cond_q;      // ...and at the previous edge
    logic       wr_start;
    logic       rd_cond;
    logic [7:0] port;

    logic [7:0] led_q;
    logic [7:0] scratch_q;
    logic [7:0] irq_q;          // [2:0] int lines, [7] nmi
    logic [7:0] rd_byte;

    logic       io_rd_q;
    logic [7:0] io_q_q;

    assign port    = bus.a[7:0];
    assign wr_cond = is_io(bus) & ~bus.wr_n;
    assign rd_cond = is_io(bus) & ~bus.rd_n;

    // *******************************************************************
    // write side
    // *******************************************************************
    assign wr_start = wr_cond & ~wr_cond_q;    // leading edge of the strobe

    always_ff @(posedge hwclk) begin
        if (rst) begin
            wr_cond_q <= 1'b0;
            led_q     <= 8'h00;     // all LEDs off
            scratch_q <= 8'h00;
            irq_q     <= 8'h00;     // no interrupts requested
        end else begin
            wr_cond_q <= wr_cond;
            if (wr_start) begin
                case (port)
                    LED_PORT:     led_q     <= d_in;
                    SCRATCH_PORT: scratch_q <= d_in;
                    IRQ_PORT:     irq_q     <= d_in;
                    default:      ;             // status and unmapped ports are read only
                endcase
            end
        end
    end

    // stored bits are active high, pins are active low
    assign led   = ~led_q;
    assign int_n = ~irq_q[2:0];
    assign nmi_n = ~irq_q[7];

    // *******************************************************************
    // read side
    // *******************************************************************
    always_comb begin
        case (port)
            LED_PORT:     rd_byte = led_q;
            SCRATCH_PORT: rd_byte = scratch_q;
            STATUS_PORT:  rd_byte = {6'b000000, halt_n, busack_n};
            IRQ_PORT:     rd_byte = irq_q;
            default:      rd_byte = 8'hff;      // open bus look
        endcase
    end

    always_ff @(posedge hwclk) begin
        if (rst) begin
            io_rd_q <= 1'b0;
        end else begin
            io_rd_q <= rd_cond;
        end
        io_q_q <= rd_byte;      // data only matters while io_rd_q is high
    end

    assign io_rd = io_rd_q;
    assign io_q  = io_q_q;

endmodule

// ==== cpu_clock_gen.sv ====
// CPU clock divider and reset stretcher; extal = hwclk / 2**CLK_DIV_BITS, CLK_DIV_BITS >= 1
`timescale 1ns/1ps

module cpu_clock_gen #(
    parameter int CLK_DIV_BITS = 1,     // divide by 2**CLK_DIV_BITS
    parameter int RESET_HOLD   = 16     // edges of CPU reset after rst drops
) (
    input  logic hwclk,
    input  logic rst,
    output logic extal,
    output logic reset_n
);

    localparam int HOLD_BITS = $clog2(RESET_HOLD + 1);

    logic [CLK_DIV_BITS-1:0] div_cnt;
    logic [HOLD_BITS-1:0]    hold_cnt;    // edges left before the CPU runs
    logic                    reset_n_q;

    // *******************************************************************
    // clock divider
    // *******************************************************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            div_cnt <= '0;      // extal starts low
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign extal = div_cnt[CLK_DIV_BITS-1];    // msb is a 50% duty clock

    // *******************************************************************
    // reset stretcher
    // *******************************************************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            hold_cnt  <= HOLD_BITS'(RESET_HOLD);
            reset_n_q <= 1'b0;
        end else if (hold_cnt != '0) begin
            hold_cnt  <= hold_cnt - 1'b1;
            reset_n_q <= (hold_cnt == HOLD_BITS'(1));   // release on the last count
        end else begin
            reset_n_q <= 1'b1;  // covers RESET_HOLD of zero
        end
    end

    assign reset_n = reset_n_q;

endmodule

// ==== data_bus_mux.sv ====
// read data return; sources arrive one edge after the strobe, output adds one more edge
`timescale 1ns/1ps

module data_bus_mux
    import bus_glue_pkg::*;
(
    input  logic       hwclk,
    input  logic       rst,
    input  logic       rom_rd,
    input  logic [7:0] rom_q,
    input  logic       io_rd,
    input  logic [7:0] io_q,
    output logic [7:0] d_out,
    output logic       d_oe       // drive the CPU data pins
);

    rd_src_t    src;
    logic [7:0] sel_byte;
    logic [7:0] d_out_q;
    logic       d_oe_q;

    // rom wins, though mreq and iorq never overlap on this CPU
    always_comb begin
        if (rom_rd) begin
            src = RD_SRC_ROM;
        end else if (io_rd) begin
            src = RD_SRC_IO;
        end else begin
            src = RD_SRC_NONE;
        end
    end

    always_comb begin
        case (src)
            RD_SRC_ROM: sel_byte = rom_q;
            RD_SRC_IO:  sel_byte = io_q;
            default:    sel_byte = 8'hff;   // bus floats high anyway
        endcase
    end

    // *******************************************************************
    // output register
    // *******************************************************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            d_oe_q <= 1'b0;     // never fight the CPU out of reset
        end else begin
            d_oe_q <= (src != RD_SRC_NONE);
        end
        d_out_q <= sel_byte;
    end

    assign d_out = d_out_q;
    assign d_oe  = d_oe_q;

endmodule

// ==== z180_glue_top.sv ====
// Z180 board glue top; data bus split in/out/oe, pad tristate lives in a board wrapper
`timescale 1ns/1ps

module z180_glue_top
    import bus_glue_pkg::*;
#(
    parameter int ROM_ADDR_BITS = 9,    // 512 byte boot ROM
    parameter int CLK_DIV_BITS  = 1,    // extal = hwclk / 2
    parameter int RESET_HOLD    = 16
) (
    input  logic        hwclk,
    input  logic        rst,

    input  logic [19:0] a,
    input  logic [7:0]  d_in,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        m1_n,
    input  logic        halt_n,
    input  logic        busack_n,

    output logic [7:0]  d_out,
    output logic        d_oe,
    output logic        ce_n,       // static RAM
    output logic        oe_n,
    output logic        we_n,
    output logic [7:0]  led,
    output logic [2:0]  int_n,
    output logic        nmi_n,
    output logic        extal,      // CPU crystal input
    output logic        reset_n,    // CPU reset
    output logic        busreq_n,
    output logic        dreq1_n,
    output logic        wait_n
);

    cpu_bus_t    bus;
    mem_strobe_t strobes;
    logic        rom_rd;
    logic [7:0]  rom_q;
    logic        io_rd;
    logic [7:0]  io_q;

    // gather the strobes into one bundle
    assign bus = '{a: a, mreq_n: mreq_n, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n, m1_n: m1_n};

    // *******************************************************************
    // blocks
    // *******************************************************************
    mem_decode #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS)
    ) u_mem_decode (
        .hwclk   (hwclk),
        .bus     (bus),
        .strobes (strobes),
        .rom_rd  (rom_rd),
        .rom_q   (rom_q)
    );

    io_ports u_io_ports (
        .hwclk    (hwclk),
        .rst      (rst),
        .bus      (bus),
        .d_in     (d_in),
        .halt_n   (halt_n),
        .busack_n (busack_n),
        .io_rd    (io_rd),
        .io_q     (io_q),
        .led      (led),
        .int_n    (int_n),
        .nmi_n    (nmi_n)
    );

    data_bus_mux u_data_bus_mux (
        .hwclk  (hwclk),
        .rst    (rst),
        .rom_rd (rom_rd),
        .rom_q  (rom_q),
        .io_rd  (io_rd),
        .io_q   (io_q),
        .d_out  (d_out),
        .d_oe   (d_oe)
    );

    cpu_clock_gen #(
        .CLK_DIV_BITS (CLK_DIV_BITS),
        .RESET_HOLD   (RESET_HOLD)
    ) u_cpu_clock_gen (
        .hwclk   (hwclk),
        .rst     (rst),
        .extal   (extal),
        .reset_n (reset_n)
    );

    assign ce_n = strobes.ce_n;
    assign oe_n = strobes.oe_n;
    assign we_n = strobes.we_n;

    // no DMA, no bus masters, no wait states
    assign busreq_n = 1'b1;
    assign dreq1_n  = 1'b1;
    assign wait_n   = 1'b1;

endmodule

// ==== tb_z180_glue.sv ====
// testbench for z180_glue_top at default parameters; run from the project root so boot_rom.hex loads
`timescale 1ns/1ps

module tb_z180_glue
    import bus_glue_pkg::*;
();

    localparam int ROM_ADDR_BITS = 9;
    localparam int CLK_DIV_BITS  = 1;
    localparam int RESET_HOLD    = 16;
    localparam int ROM_BYTES     = 1 << ROM_ADDR_BITS;
    localparam int EXTAL_HALF    = 1 << (CLK_DIV_BITS - 1);    // hwclk edges per extal level
    localparam int N_BUS_CYCLES  = 400;
    localparam int HOLD_CYCLES   = 4;
    localparam int TIMEOUT       = HOLD_CYCLES * N_BUS_CYCLES + 200;

    logic        hwclk;
    logic        rst;
    logic [19:0] a;
    logic [7:0]  d_in;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic        halt_n;
    logic        busack_n;
    logic [7:0]  d_out;
    logic        d_oe;
    logic        ce_n;
    logic        oe_n;
    logic        we_n;
    logic [7:0]  led;
    logic [2:0]  int_n;
    logic        nmi_n;
    logic        extal;
    logic        reset_n;
    logic        busreq_n;
    logic        dreq1_n;
    logic        wait_n;

    // reference model state
    logic [7:0]  rom_img [0:ROM_BYTES-1];
    logic [7:0]  m_led;             // stored bytes, active high
    logic [7:0]  m_scratch;
    logic [7:0]  m_irq;
    logic        m_wr_prev;         // io write seen at the previous edge
    logic        s1_vld;            // read pipeline, one edge in
    logic [7:0]  s1_byte;
    logic        s2_vld;            // two edges in, what d_out shows
    logic [7:0]  s2_byte;
    int unsigned edges_run;         // edges since rst dropped
    int unsigned errors;
    int unsigned checks;
    int unsigned cycles;

    z180_glue_top u_z180_glue_top (
        .hwclk (hwclk), .rst (rst),
        .a (a), .d_in (d_in), .mreq_n (mreq_n), .iorq_n (iorq_n), .rd_n (rd_n), .wr_n (wr_n),
        .m1_n (m1_n), .halt_n (halt_n), .busack_n (busack_n),
        .d_out (d_out), .d_oe (d_oe), .ce_n (ce_n), .oe_n (oe_n), .we_n (we_n),
        .led (led), .int_n (int_n), .nmi_n (nmi_n), .extal (extal), .reset_n (reset_n),
        .busreq_n (busreq_n), .dreq1_n (dreq1_n), .wait_n (wait_n)
    );

    always #50 hwclk = ~hwclk;     // 100 ns period

    // run limit
    always @(posedge hwclk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("sim failed");
            $finish;
        end
    end

    // *******************************************************************
    // reference model, stepped once per rising edge
    // *******************************************************************
    // called at the falling edge, inputs still hold what the last rising edge saw
    task automatic update_model();
        logic       io_cyc;
        logic       io_wr;
        logic [7:0] port_val;
        if (rst) begin
            m_led     = 8'h00;
            m_scratch = 8'h00;
            m_irq     = 8'h00;
            m_wr_prev = 1'b0;
            s1_vld    = 1'b0;
            s2_vld    = 1'b0;
            edges_run = 0;
        end else begin
            io_cyc = !iorq_n && m1_n;           // int ack is not io
            io_wr  = io_cyc && !wr_n;
            case (a[7:0])                       // values before this edge's write
                LED_PORT:     port_val = m_led;
                SCRATCH_PORT: port_val = m_scratch;
                STATUS_PORT:  port_val = {6'd0, halt_n, busack_n};
                IRQ_PORT:     port_val = m_irq;
                default:      port_val = 8'hff;
            endcase
            s2_vld  = s1_vld;
            s2_byte = s1_byte;
            if (!mreq_n && !rd_n && a < ROM_BYTES) begin
                s1_vld  = 1'b1;
                s1_byte = rom_img[a[ROM_ADDR_BITS-1:0]];
            end else if (io_cyc && !rd_n) begin
                s1_vld  = 1'b1;
                s1_byte = port_val;
            end else begin
                s1_vld  = 1'b0;                 // SRAM and idle leave the bus alone
            end
            if (io_wr && !m_wr_prev) begin      // first edge of the write only
                case (a[7:0])
                    LED_PORT:     m_led     = d_in;
                    SCRATCH_PORT: m_scratch = d_in;
                    IRQ_PORT:     m_irq     = d_in;
                    default:      ;
                endcase
            end
            m_wr_prev = io_wr;
            edges_run++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s = %h, expected %h (cycle %0d)", name, got, exp, cycles);
        end
    endtask

    task automatic check_outputs();
        logic       exp_extal;
        logic       exp_reset_n;
        logic [7:0] exp_led;
        logic [2:0] exp_int_n;
        logic       exp_nmi_n;
        exp_extal   = ((edges_run / EXTAL_HALF) % 2) == 1;   // low out of reset
        exp_reset_n = (edges_run >= RESET_HOLD);
        exp_led     = ~m_led;                                // pins are active low
        exp_int_n   = ~m_irq[2:0];
        exp_nmi_n   = ~m_irq[7];
        check_value("ce_n", 32'(ce_n), 32'(mreq_n || a < ROM_BYTES));
        check_value("oe_n", 32'(oe_n), 32'(mreq_n || rd_n));
        check_value("we_n", 32'(we_n), 32'(mreq_n || wr_n));
        check_value("d_oe", 32'(d_oe), 32'(s2_vld));
        if (s2_vld) begin
            check_value("d_out", 32'(d_out), 32'(s2_byte));
        end
        check_value("led", 32'(led), 32'(exp_led));
        check_value("int_n", 32'(int_n), 32'(exp_int_n));
        check_value("nmi_n", 32'(nmi_n), 32'(exp_nmi_n));
        check_value("extal", 32'(extal), 32'(exp_extal));
        check_value("reset_n", 32'(reset_n), 32'(exp_reset_n));
        check_value("busreq_n", 32'(busreq_n), 32'd1);
        check_value("dreq1_n", 32'(dreq1_n), 32'd1);
        check_value("wait_n", 32'(wait_n), 32'd1);
    endtask

    // one falling edge: step the model, compare, then the caller drives
    task automatic tick();
        @(negedge hwclk);
        update_model();
        check_outputs();
    endtask

    // *******************************************************************
    // stimulus
    // *******************************************************************
    function automatic logic [19:0] pick_mem_addr();
        logic [31:0] r;
        r = $urandom;
        if (r[31]) begin
            return {11'd0, r[8:0]};             // force a hit in the boot ROM
        end else begin
            return r[19:0];
        end
    endfunction

    function automatic logic [19:0] pick_io_addr();
        logic [31:0] r;
        logic [7:0]  port;
        r = $urandom;
        if (r[30:28] < 3'd6) begin
            port = 8'h40 + {5'd0, r[30:28]};    // mapped ports plus two empty ones
        end else begin
            port = r[7:0];
        end
        return {r[19:8], port};                 // junk in the upper bits
    endfunction

    task automatic set_idle();
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        m1_n   = 1'b1;
    endtask

    task automatic drive_bus_cycle(input int kind);
        logic [31:0] r;
        r = $urandom;
        set_idle();
        d_in     = r[7:0];
        halt_n   = r[8];
        busack_n = r[9];
        case (kind)
            0: begin a = pick_mem_addr(); mreq_n = 1'b0; rd_n = 1'b0; end
            1: begin a = pick_mem_addr(); mreq_n = 1'b0; wr_n = 1'b0; end
            2: begin a = pick_io_addr();  iorq_n = 1'b0; rd_n = 1'b0; end
            3: begin a = pick_io_addr();  iorq_n = 1'b0; wr_n = 1'b0; end
            4: begin                             // int ack, strobes tried at random
                a      = pick_io_addr();
                iorq_n = 1'b0;
                m1_n   = 1'b0;
                rd_n   = r[10];
                wr_n   = r[11];
            end
            default: a = r[31:12];
        endcase
    endtask

    initial begin
        int unsigned seed_ret;
        int          kind;
        seed_ret = $urandom(32'h021b_5024);
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        hwclk    = 1'b0;
        rst      = 1'b1;
        a        = 20'd0;
        d_in     = 8'd0;
        halt_n   = 1'b1;
        busack_n = 1'b1;
        set_idle();
        $readmemh("boot_rom.hex", rom_img);    // same image the DUT loads

        repeat (10) tick();
        rst = 1'b0;                             // reset_n count starts here

        for (int i = 0; i < N_BUS_CYCLES; i++) begin
            kind = $urandom_range(5, 0);
            for (int c = 0; c < HOLD_CYCLES; c++) begin
                tick();
                if (c == 0) begin
                    drive_bus_cycle(kind);
                end else begin
                    d_in = 8'($urandom);        // data moves under a held strobe
                end
            end
        end
        set_idle();
        repeat (4) tick();                      // let the read pipe drain

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== boot_rom.hex ====
// 512 bytes, 16 per line from address 000; byte = addr[7:0] xor a5 when addr[8] is set
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F
50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF
F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 FA FB FC FD FE FF
A5 A4 A7 A6 A1 A0 A3 A2 AD AC AF AE A9 A8 AB AA
B5 B4 B7 B6 B1 B0 B3 B2 BD BC BF BE B9 B8 BB BA
85 84 87 86 81 80 83 82 8D 8C 8F 8E 89 88 8B 8A
95 94 97 96 91 90 93 92 9D 9C 9F 9E 99 98 9B 9A
E5 E4 E7 E6 E1 E0 E3 E2 ED EC EF EE E9 E8 EB EA
F5 F4 F7 F6 F1 F0 F3 F2 FD FC FF FE F9 F8 FB FA
C5 C4 C7 C6 C1 C0 C3 C2 CD CC CF CE C9 C8 CB CA
D5 D4 D7 D6 D1 D0 D3 D2 DD DC DF DE D9 D8 DB DA
25 24 27 26 21 20 23 22 2D 2C 2F 2E 29 28 2B 2A
35 34 37 36 31 30 33 32 3D 3C 3F 3E 39 38 3B 3A
05 04 07 06 01 00 03 02 0D 0C 0F 0E 09 08 0B 0A
15 14 17 16 11 10 13 12 1D 1C 1F 1E 19 18 1B 1A
65 64 67 66 61 60 63 62 6D 6C 6F 6E 69 68 6B 6A
75 74 77 76 71 70 73 72 7D 7C 7F 7E 79 78 7B 7A
45 44 47 46 41 40 43 42 4D 4C 4F 4E 49 48 4B 4A
55 54 57 56 51 50 53 52 5D 5C 5F 5E 59 58 5B 5A

// ==== files.f ====
bus_glue_pkg.sv
boot_rom.sv
mem_decode.sv
io_ports.sv
cpu_clock_gen.sv
data_bus_mux.sv
z180_glue_top.sv
tb_z180_glue.sv

// ==== Makefile ====
# Verilator build and run for the Z180 glue testbench

VERILATOR ?= verilator
TOP       ?= tb_z180_glue
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
ROM_HEX   ?= boot_rom.hex
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN) $(ROM_HEX)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
